//--- hdl/tpu_defines.svh
`ifndef TPU_DEFINES_SVH
`define TPU_DEFINES_SVH

// array edge
`define TPU_DIM 4

// operand and accumulator widths
`define TPU_ELEM_W 8
`define TPU_ACC_W 32

// job dimension widths
`define TPU_K_W 10
`define TPU_M_W 11
`define TPU_N_W 9

// buffer index widths
`define TPU_A_IDX_W 14
`define TPU_B_IDX_W 12
`define TPU_C_IDX_W 11

// one packed column of A or row of B
`define TPU_IN_W (`TPU_DIM * `TPU_ELEM_W)

// one row of C
`define TPU_ROW_W (`TPU_DIM * `TPU_ACC_W)

`endif

//--- hdl/tpu_pkg.sv
`include "tpu_defines.svh"

package tpu_pkg;

    // job size as given with start
    typedef struct packed {
        logic [`TPU_K_W-1:0] k;
        logic [`TPU_M_W-1:0] m;
        logic [`TPU_N_W-1:0] n;
    } tpu_dims_t;

    // one cycle of buffer data with its step tags
    typedef struct packed {
        logic [`TPU_IN_W-1:0] a_word;
        logic [`TPU_IN_W-1:0] b_word;
        logic                 first;
        logic                 last;
        logic                 job_last;
    } feed_t;

    // one byte lane after skewing
    typedef struct packed {
        logic [`TPU_ELEM_W-1:0] a;
        logic [`TPU_ELEM_W-1:0] b;
        logic                   first;
        logic                   last;
        logic                   job_last;
    } lane_t;

    typedef struct packed {
        logic                    en;
        logic [`TPU_C_IDX_W-1:0] index;
        logic [`TPU_ROW_W-1:0]   data;
    } c_write_t;

endpackage

//--- hdl/tile_sequencer.sv
`include "tpu_defines.svh"

module tile_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  tpu_pkg::tpu_dims_t      dims,
    input  logic                    job_done,
    input  logic [`TPU_IN_W-1:0]    a_data,
    input  logic [`TPU_IN_W-1:0]    b_data,
    output logic                    busy,
    output logic [`TPU_A_IDX_W-1:0] a_index,
    output logic [`TPU_B_IDX_W-1:0] b_index,
    output tpu_pkg::feed_t          feed,
    output logic                    feed_en
);

    tpu_pkg::tpu_dims_t   dims_q;
    logic                 feeding;
    logic [`TPU_K_W-1:0]  cnt_k;
    logic [`TPU_M_W-1:0]  cnt_m;
    logic [`TPU_N_W-1:0]  cnt_n;
    logic [`TPU_K_W-1:0]  k_last;
    logic [`TPU_M_W-1:0]  m_last;
    logic [`TPU_N_W-1:0]  n_last;
    logic                 k_end;
    logic                 m_end;
    logic                 n_end;
    logic                 accept;

    assign accept = start & ~busy;

    // last counter values, tile counts are dims over the array edge
    assign k_last = dims_q.k - 1'b1;
    assign m_last = `TPU_M_W'(dims_q.m / `TPU_DIM - 1);
    assign n_last = `TPU_N_W'(dims_q.n / `TPU_DIM - 1);

    assign k_end = (cnt_k == k_last);
    assign m_end = (cnt_m == m_last);
    assign n_end = (cnt_n == n_last);

    always_ff @(posedge clk) begin
        if (accept) begin
            dims_q <= dims;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            feeding <= 1'b0;
            cnt_k   <= '0;
            cnt_m   <= '0;
            cnt_n   <= '0;
            a_index <= '0;
            b_index <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            feeding <= 1'b1;
            cnt_k   <= '0;
            cnt_m   <= '0;
            cnt_n   <= '0;
            a_index <= '0;
            b_index <= '0;
        end else begin
            if (job_done) begin
                busy <= 1'b0;
            end
            if (feeding) begin
                if (!k_end) begin
                    cnt_k   <= cnt_k + 1'b1;
                    a_index <= a_index + 1'b1;
                    b_index <= b_index + 1'b1;
                end else if (!m_end) begin
                    // next row tile, same column tile
                    cnt_k   <= '0;
                    cnt_m   <= cnt_m + 1'b1;
                    a_index <= a_index + 1'b1;
                    b_index <= b_index - `TPU_B_IDX_W'(k_last);
                end else if (!n_end) begin
                    cnt_k   <= '0;
                    cnt_m   <= '0;
                    cnt_n   <= cnt_n + 1'b1;
                    a_index <= '0;
                    b_index <= b_index + 1'b1;
                end else begin
                    feeding <= 1'b0;
                end
            end
        end
    end

    // buffer data comes back in the same cycle
    assign feed.a_word   = a_data;
    assign feed.b_word   = b_data;
    assign feed.first    = (cnt_k == '0);
    assign feed.last     = k_end;
    assign feed.job_last = k_end & m_end & n_end;
    assign feed_en       = feeding;

endmodule

//--- hdl/skew_buffer.sv
`include "tpu_defines.svh"

module skew_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  tpu_pkg::feed_t feed,
    input  logic           feed_en,
    output tpu_pkg::lane_t lanes [`TPU_DIM]
);

    genvar i;

    generate
        for (i = 0; i < `TPU_DIM; i++) begin : g_lane
            tpu_pkg::lane_t split;
            tpu_pkg::lane_t dly [i+1];

            // byte 0 sits in the top bits of the word
            always_comb begin
                split.a        = feed.a_word[(`TPU_DIM-1-i)*`TPU_ELEM_W +: `TPU_ELEM_W];
                split.b        = feed.b_word[(`TPU_DIM-1-i)*`TPU_ELEM_W +: `TPU_ELEM_W];
                split.first    = feed_en & feed.first;
                split.last     = feed_en & feed.last;
                split.job_last = feed_en & feed.job_last;
            end

            // stage 0 is common to all lanes, then i more
            always_ff @(posedge clk) begin
                dly[0] <= split;
                for (int d = 1; d <= i; d++) begin
                    dly[d] <= dly[d-1];
                end
                if (!rst_n) begin
                    for (int d = 0; d <= i; d++) begin
                        dly[d].first    <= 1'b0;
                        dly[d].last     <= 1'b0;
                        dly[d].job_last <= 1'b0;
                    end
                end
            end

            assign lanes[i] = dly[i];
        end
    endgenerate

endmodule

//--- hdl/mac_cell.sv
`include "tpu_defines.svh"

module mac_cell (
    input  logic                   clk,
    input  logic                   rst_n,
    input  tpu_pkg::lane_t         a_in,
    input  logic [`TPU_ELEM_W-1:0] b_in,
    output tpu_pkg::lane_t         a_out,
    output logic [`TPU_ELEM_W-1:0] b_out,
    output logic [`TPU_ACC_W-1:0]  result
);

    logic [2*`TPU_ELEM_W-1:0] prod;
    logic [`TPU_ACC_W-1:0]    acc;
    logic [`TPU_ACC_W-1:0]    sum;
    logic [`TPU_ACC_W-1:0]    hold;

    assign prod = a_in.a * b_in;

    // first starts a new dot product
    assign sum = (a_in.first ? '0 : acc) + `TPU_ACC_W'(prod);

    always_ff @(posedge clk) begin
        acc <= sum;
        if (a_in.last) begin
            hold <= sum;
        end
        a_out <= a_in;
        b_out <= b_in;
        if (!rst_n) begin
            a_out.first    <= 1'b0;
            a_out.last     <= 1'b0;
            a_out.job_last <= 1'b0;
        end
    end

    // stays valid until the next tile's last arrives
    assign result = hold;

endmodule

//--- hdl/systolic_array.sv
`include "tpu_defines.svh"

module systolic_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  tpu_pkg::lane_t        lanes [`TPU_DIM],
    output logic [`TPU_DIM-1:0]   row_done,
    output logic                  row_final,
    output logic [`TPU_ROW_W-1:0] row_data [`TPU_DIM]
);

    tpu_pkg::lane_t         h_bus [`TPU_DIM][`TPU_DIM+1];
    logic [`TPU_ELEM_W-1:0] v_bus [`TPU_DIM+1][`TPU_DIM];
    logic [`TPU_ACC_W-1:0]  cell_res [`TPU_DIM][`TPU_DIM];

    genvar i, j;

    generate
        for (i = 0; i < `TPU_DIM; i++) begin : g_row
            // the b byte of lane i feeds column i instead
            assign h_bus[i][0] = '{
                a:        lanes[i].a,
                b:        '0,
                first:    lanes[i].first,
                last:     lanes[i].last,
                job_last: lanes[i].job_last
            };
            assign v_bus[0][i] = lanes[i].b;

            for (j = 0; j < `TPU_DIM; j++) begin : g_col
                mac_cell mac_cell_i (
                    .clk    (clk),
                    .rst_n  (rst_n),
                    .a_in   (h_bus[i][j]),
                    .b_in   (v_bus[i][j]),
                    .a_out  (h_bus[i][j+1]),
                    .b_out  (v_bus[i+1][j]),
                    .result (cell_res[i][j])
                );
            end

            // last has left the rightmost cell
            assign row_done[i] = h_bus[i][`TPU_DIM].last;
        end
    endgenerate

    assign row_final = h_bus[`TPU_DIM-1][`TPU_DIM].job_last;

    // column 0 goes to the top bits
    always_comb begin
        for (int r = 0; r < `TPU_DIM; r++) begin
            for (int c = 0; c < `TPU_DIM; c++) begin
                row_data[r][(`TPU_DIM-1-c)*`TPU_ACC_W +: `TPU_ACC_W] = cell_res[r][c];
            end
        end
    end

endmodule

//--- hdl/result_drain.sv
`include "tpu_defines.svh"

module result_drain (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [`TPU_DIM-1:0]   row_done,
    input  logic                  row_final,
    input  logic [`TPU_ROW_W-1:0] row_data [`TPU_DIM],
    output tpu_pkg::c_write_t     c_wr,
    output logic                  job_done
);

    logic [`TPU_C_IDX_W-1:0] c_index;
    logic [`TPU_ROW_W-1:0]   sel_row;
    logic                    wr_en;

    assign wr_en = |row_done;

    // at most one row finishes per cycle
    always_comb begin
        sel_row = '0;
        for (int i = 0; i < `TPU_DIM; i++) begin
            if (row_done[i]) begin
                sel_row = row_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            c_index <= '0;
        end else if (start) begin
            c_index <= '0;
        end else if (wr_en) begin
            c_index <= c_index + 1'b1;
        end
    end

    assign c_wr = '{en: wr_en, index: c_index, data: sel_row};

    // bottom row of the last tile
    assign job_done = row_done[`TPU_DIM-1] & row_final;

endmodule

//--- hdl/tpu_top.sv
`include "tpu_defines.svh"

module tpu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  tpu_pkg::tpu_dims_t      dims,
    output logic                    busy,
    output logic [`TPU_A_IDX_W-1:0] a_index,
    input  logic [`TPU_IN_W-1:0]    a_data,
    output logic [`TPU_B_IDX_W-1:0] b_index,
    input  logic [`TPU_IN_W-1:0]    b_data,
    output tpu_pkg::c_write_t       c_wr
);

    tpu_pkg::feed_t        feed;
    logic                  feed_en;
    tpu_pkg::lane_t        lanes [`TPU_DIM];
    logic [`TPU_DIM-1:0]   row_done;
    logic                  row_final;
    logic [`TPU_ROW_W-1:0] row_data [`TPU_DIM];
    logic                  job_done;
    logic                  job_start;

    // start while busy is dropped
    assign job_start = start & ~busy;

    tile_sequencer tile_sequencer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .dims     (dims),
        .job_done (job_done),
        .a_data   (a_data),
        .b_data   (b_data),
        .busy     (busy),
        .a_index  (a_index),
        .b_index  (b_index),
        .feed     (feed),
        .feed_en  (feed_en)
    );

    skew_buffer skew_buffer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .feed    (feed),
        .feed_en (feed_en),
        .lanes   (lanes)
    );

    systolic_array systolic_array_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .lanes     (lanes),
        .row_done  (row_done),
        .row_final (row_final),
        .row_data  (row_data)
    );

    result_drain result_drain_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (job_start),
        .row_done  (row_done),
        .row_final (row_final),
        .row_data  (row_data),
        .c_wr      (c_wr),
        .job_done  (job_done)
    );

endmodule

//--- bench/tpu_chk.sv
`include "tpu_defines.svh"

module tpu_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                start,
    input tpu_pkg::tpu_dims_t  dims,
    input logic                busy,
    input tpu_pkg::c_write_t   c_wr
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned             fail_count = 0;
    logic                    seen_write;
    logic [`TPU_C_IDX_W-1:0] last_index;
    int unsigned             write_count;
    int unsigned             write_goal;

    // job bookkeeping, restarted by an accepted start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen_write  <= 1'b0;
            last_index  <= '0;
            write_count <= 0;
            write_goal  <= 0;
        end else if (start && !busy) begin
            seen_write  <= 1'b0;
            write_count <= 0;
            write_goal  <= (int'(dims.m) * int'(dims.n)) / `TPU_DIM;
        end else if (c_wr.en) begin
            seen_write  <= 1'b1;
            last_index  <= c_wr.index;
            write_count <= write_count + 1;
        end
    end

    a_wr_in_job: assert property (@(posedge clk) disable iff (!rst_n) c_wr.en |-> busy)
        else begin fail_count++; $error("write strobe seen while not busy"); end

    // first write of a job goes to index zero
    a_index_step: assert property (@(posedge clk) disable iff (!rst_n)
        c_wr.en |-> c_wr.index == (seen_write ? `TPU_C_IDX_W'(last_index + 1'b1) : '0))
        else begin fail_count++; $error("C index did not step by one"); end

    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !busy && !c_wr.en)
        else begin fail_count++; $error("busy or write strobe high after reset"); end

    a_write_total: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> write_count == write_goal)
        else begin fail_count++; $error("busy fell before all rows were written"); end

endmodule

bind tpu_top tpu_chk tpu_chk_i (.*);

//--- bench/tpu_tb.sv
`include "tpu_defines.svh"

module tpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 1000;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    tpu_pkg::tpu_dims_t      dims;
    logic                    busy;
    logic [`TPU_A_IDX_W-1:0] a_index;
    logic [`TPU_IN_W-1:0]    a_data;
    logic [`TPU_B_IDX_W-1:0] b_index;
    logic [`TPU_IN_W-1:0]    b_data;
    tpu_pkg::c_write_t       c_wr;
    logic [31:0]             rng_state;

    // buffer models read back in the same cycle
    logic [`TPU_IN_W-1:0] a_mem [0:(1 << `TPU_A_IDX_W)-1];
    logic [`TPU_IN_W-1:0] b_mem [0:(1 << `TPU_B_IDX_W)-1];

    assign a_data = a_mem[a_index];
    assign b_data = b_mem[b_index];

    tpu_top tpu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal;
    endtask

    task automatic check_value(input string what, input logic [`TPU_ROW_W-1:0] expected,
                               input logic [`TPU_ROW_W-1:0] actual);
        assert (actual === expected)
            else fail_run($sformatf("Error %s: expected %0h, actual %0h", what, expected, actual));
    endtask

    task automatic fill_buffers(input int k, input int m, input int n, input bit all_ones);
        for (int w = 0; w < (m / `TPU_DIM) * k; w++) begin
            rng_state = xorshift32(rng_state);
            a_mem[w] = all_ones ? '1 : `TPU_IN_W'(rng_state);
        end
        for (int w = 0; w < (n / `TPU_DIM) * k; w++) begin
            rng_state = xorshift32(rng_state);
            b_mem[w] = all_ones ? '1 : `TPU_IN_W'(rng_state);
        end
    endtask

    // C word h is row h mod M of column tile h div M with byte 0 on top
    function automatic logic [`TPU_ROW_W-1:0] expected_row(input int h, input int k, input int m);
        logic [`TPU_ROW_W-1:0]  row;
        logic [`TPU_ELEM_W-1:0] a_b;
        logic [`TPU_ELEM_W-1:0] b_b;
        longint                 sum;
        int                     r;
        int                     col;
        r = h % m;
        for (int j = 0; j < `TPU_DIM; j++) begin
            col = (h / m) * `TPU_DIM + j;
            sum = 0;
            for (int s = 0; s < k; s++) begin
                a_b = a_mem[(r / `TPU_DIM) * k + s][(`TPU_DIM-1-(r % `TPU_DIM))*`TPU_ELEM_W +: 8];
                b_b = b_mem[(col / `TPU_DIM) * k + s][(`TPU_DIM-1-j)*`TPU_ELEM_W +: 8];
                sum += longint'(a_b) * longint'(b_b);
            end
            row[(`TPU_DIM-1-j)*`TPU_ACC_W +: `TPU_ACC_W] = 32'(sum);
        end
        return row;
    endfunction

    task automatic run_job(input string name, input int k, input int m, input int n,
                           input bit all_ones, input bit poke);
        int writes;
        int cycles;
        fill_buffers(k, m, n, all_ones);
        start = 1'b1;
        dims = '{k: `TPU_K_W'(k), m: `TPU_M_W'(m), n: `TPU_N_W'(n)};
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value({name, " busy after start"}, `TPU_ROW_W'(1), `TPU_ROW_W'(busy));
        writes = 0;
        cycles = 0;
        while (busy) begin
            if (c_wr.en) begin
                check_value($sformatf("%s index %0d", name, writes),
                            `TPU_ROW_W'(writes), `TPU_ROW_W'(c_wr.index));
                check_value($sformatf("%s data %0d", name, writes),
                            expected_row(writes, k, m), c_wr.data);
                writes++;
            end
            // a second start mid job with other dims
            start = poke && cycles == 3;
            if (poke && cycles == 3) begin
                dims = '{k: `TPU_K_W'(5), m: `TPU_M_W'(16), n: `TPU_N_W'(16)};
            end
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("job %s did not finish in %0d cycles", name, TIMEOUT));
            end
        end
        check_value({name, " write count"}, `TPU_ROW_W'(m * n / `TPU_DIM), `TPU_ROW_W'(writes));
    endtask

    always @(posedge clk) begin
        if (tpu_top_i.tpu_chk_i.fail_count != 0) begin
            fail_run("a port assertion on the DUT failed");
        end
    end

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        dims = '0;
        rng_state = 32'd37;
        foreach (a_mem[w]) a_mem[w] = `TPU_IN_W'(w);
        foreach (b_mem[w]) b_mem[w] = `TPU_IN_W'(w);
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        run_job("single_tile", 4, 4, 4, 1'b0, 1'b0);
        run_job("four_tiles", 9, 8, 8, 1'b0, 1'b0);
        run_job("back_to_back", 5, 4, 8, 1'b0, 1'b0);
        run_job("start_while_busy", 6, 8, 4, 1'b0, 1'b1);
        run_job("all_ones_k20", 20, 4, 4, 1'b1, 1'b0);
        repeat (4) @(posedge clk);
        if (tpu_top_i.tpu_chk_i.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("a port assertion on the DUT failed");
        end
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/tpu_pkg.sv
hdl/tile_sequencer.sv
hdl/skew_buffer.sv
hdl/mac_cell.sv
hdl/systolic_array.sv
hdl/result_drain.sv
hdl/tpu_top.sv
bench/tpu_chk.sv
bench/tpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tpu_tb -f filelist.f -o tpu_sim \
    && ./obj_dir/tpu_sim +verilator+error+limit+100 | tee /dev/stderr \
    | grep -q "^Result: PASSED$" && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
